// File: Bender.yml
package:
  name: slm_bridge

sources:
  - src/slm_bridge_pkg.sv
  - src/uart_rx.sv
  - src/uart_tx.sv
  - src/cmd_pairer.sv
  - src/spi_master.sv
  - src/reply_queue.sv
  - src/slm_reset_gen.sv
  - src/slm_bridge_top.sv
  - target: test
    files:
      - tb/spi_slave_model.sv
      - tb/tb_slm_bridge_top.sv

// File: slm_bridge_top.f
src/slm_bridge_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_pairer.sv
src/spi_master.sv
src/reply_queue.sv
src/slm_reset_gen.sv
src/slm_bridge_top.sv
tb/spi_slave_model.sv
tb/tb_slm_bridge_top.sv

// File: src/cmd_pairer.sv
// groups received bytes in arrival order, address first, data second
// pairing restarts only on reset, a lost byte shifts every later pair
// spi_start_o follows the second rx_valid_i by exactly one cycle

`timescale 1ns/1ps
`default_nettype none

module cmd_pairer (
  input  logic                      sys_clk,
  input  logic                      reset_all_cmd_w,
  input  logic                      rx_valid_i,
  input  slm_bridge_pkg::byte_t     rx_byte_i,
  output logic                      spi_start_o,
  output slm_bridge_pkg::spi_word_t spi_word_o
);

  import slm_bridge_pkg::*;

  // address byte waiting for its data byte
  byte_t held_byte;
  // high once the first byte of a pair is in
  logic  odd_seen;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      odd_seen    <= 1'b0;
      spi_start_o <= 1'b0;
    end else begin
      spi_start_o <= 1'b0;
      if (rx_valid_i) begin
        held_byte <= rx_byte_i;
        odd_seen  <= ~odd_seen;
        // second byte closes the pair
        if (odd_seen) begin
          spi_word_o  <= {held_byte, rx_byte_i};
          spi_start_o <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/reply_queue.sv
// small FIFO between the SPI reply and the UART transmitter
// a reply that finds the queue full is lost
// each entry leaves as one tx_start_o pulse, one cycle after the pop
// REPLY_DEPTH need not be a power of two

`timescale 1ns/1ps
`default_nettype none

module reply_queue (
  input  logic                  sys_clk,
  input  logic                  reset_all_cmd_w,
  input  logic                  spi_done_i,
  input  slm_bridge_pkg::byte_t reply_byte_i,
  input  logic                  tx_busy_i,
  output logic                  tx_start_o,
  output slm_bridge_pkg::byte_t tx_byte_o
);

  import slm_bridge_pkg::*;

  byte_t                            mem [REPLY_DEPTH];
  logic [$clog2(REPLY_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(REPLY_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(REPLY_DEPTH+1)-1:0] count;
  logic                             push;
  logic                             pop;

  assign push = spi_done_i && (int'(count) != REPLY_DEPTH);
  // tx_busy_i lags tx_start_o by a cycle, so block the pop behind a pulse
  assign pop  = (count != '0) && !tx_busy_i && !tx_start_o;

  // storage and read data
  always_ff @(posedge sys_clk) begin
    if (push) begin
      mem[wr_ptr] <= reply_byte_i;
    end
    if (pop) begin
      tx_byte_o <= mem[rd_ptr];
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      tx_start_o <= 1'b0;
    end else begin
      tx_start_o <= pop;
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == REPLY_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == REPLY_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/slm_bridge_pkg.sv
// shared types and constants for the UART to SPI bridge
// DEFAULT_CLKS_PER_BIT assumes a 100 MHz sys_clk and 115200 baud
// REPLY_DEPTH is expected to stay small, the queue is built from flops

`default_nettype none

package slm_bridge_pkg;

  // one UART or SPI byte
  typedef logic [7:0] byte_t;

  // spi frame word, address in [15:8] and data in [7:0]
  typedef logic [15:0] spi_word_t;

  // 100e6 / 115200 rounded down
  localparam int DEFAULT_CLKS_PER_BIT = 868;

  // sys_clk cycles per SCK half period
  localparam int SPI_CLK_DIV = 4;
  localparam int SPI_FRAME_BITS = 16;

  // cycles the SLM stays in reset after the command drops
  localparam int RESET_HOLD_CYCLES = 10;

  // reply bytes waiting for the UART
  localparam int REPLY_DEPTH = 4;

endpackage

`default_nettype wire

// File: src/slm_bridge_top.sv
// UART to SPI control bridge for the SLM board
// byte pairs from the PC become 16-bit SPI writes, address first
// each reply byte from the SLM goes back over UART TX
// CLKS_PER_BIT sets the baud rate, at least 4

`timescale 1ns/1ps
`default_nettype none

module slm_bridge_top #(
  parameter int CLKS_PER_BIT = slm_bridge_pkg::DEFAULT_CLKS_PER_BIT
) (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  input  logic spi_sout_i,
  output logic uart_tx_o,
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_sdat_o,
  output logic slm_reset_n_o
);

  import slm_bridge_pkg::*;

  logic      rx_valid;
  byte_t     rx_byte;
  logic      spi_start;
  spi_word_t spi_word;
  logic      spi_done;
  byte_t     reply_byte;
  logic      tx_start;
  byte_t     tx_byte;
  logic      tx_busy;

  //////////////////////////////////////////////////
  // PC to SLM
  //////////////////////////////////////////////////

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_rx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  cmd_pairer u_cmd_pairer (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .spi_start_o     (spi_start),
    .spi_word_o      (spi_word)
  );

  // busy flag not needed here, starts during a frame are dropped inside
  spi_master u_spi_master (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_start_i     (spi_start),
    .spi_word_i      (spi_word),
    .spi_sout_i      (spi_sout_i),
    .spi_sen_o       (spi_sen_o),
    .spi_sck_o       (spi_sck_o),
    .spi_sdat_o      (spi_sdat_o),
    .spi_busy_o      (),
    .spi_done_o      (spi_done),
    .reply_byte_o    (reply_byte)
  );

  //////////////////////////////////////////////////
  // SLM replies back to PC
  //////////////////////////////////////////////////

  reply_queue u_reply_queue (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_done_i      (spi_done),
    .reply_byte_i    (reply_byte),
    .tx_busy_i       (tx_busy),
    .tx_start_o      (tx_start),
    .tx_byte_o       (tx_byte)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_tx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_start_i      (tx_start),
    .tx_byte_i       (tx_byte),
    .uart_tx_o       (uart_tx_o),
    .tx_busy_o       (tx_busy)
  );

  // SLM reset pin
  slm_reset_gen u_slm_reset_gen (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .slm_reset_n_o   (slm_reset_n_o)
  );

endmodule

`default_nettype wire

// File: src/slm_reset_gen.sv
// active-low SLM reset, stretched past the reset command
// low while the command is high and RESET_HOLD_CYCLES cycles after it

`timescale 1ns/1ps
`default_nettype none

module slm_reset_gen (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  output logic slm_reset_n_o
);

  import slm_bridge_pkg::*;

  // cycles of hold still to go
  logic [$clog2(RESET_HOLD_CYCLES+1)-1:0] hold_cnt;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      hold_cnt <= $bits(hold_cnt)'(RESET_HOLD_CYCLES);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // command itself pulls the pin low in the same cycle
  assign slm_reset_n_o = !reset_all_cmd_w && (hold_cnt == '0);

endmodule

`default_nettype wire

// File: src/spi_master.sv
// 16-bit SPI master, mode 0, MSB first, one frame per start strobe
// SEN falls one cycle after spi_start_i and stays low for
// SPI_FRAME_BITS * 2 * SPI_CLK_DIV cycles
// a start strobe while busy is ignored
// reply_byte_o holds the last 8 bits sampled, the lower half of the frame

`timescale 1ns/1ps
`default_nettype none

module spi_master (
  input  logic                      sys_clk,
  input  logic                      reset_all_cmd_w,
  input  logic                      spi_start_i,
  input  slm_bridge_pkg::spi_word_t spi_word_i,
  input  logic                      spi_sout_i,
  output logic                      spi_sen_o,
  output logic                      spi_sck_o,
  output logic                      spi_sdat_o,
  output logic                      spi_busy_o,
  output logic                      spi_done_o,
  output slm_bridge_pkg::byte_t     reply_byte_o
);

  import slm_bridge_pkg::*;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_DONE
  } spi_state_t;

  spi_state_t                              state;
  // position inside one SCK half period
  logic [$clog2(SPI_CLK_DIV)-1:0]          div_cnt;
  // number of SCK edges so far in the frame
  logic [$clog2(2 * SPI_FRAME_BITS)-1:0]   edge_cnt;
  spi_word_t                               tx_sh;
  byte_t                                   rx_sh;

  assign reply_byte_o = rx_sh;

  //////////////////////////////////////////////////
  // frame sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state      <= SPI_IDLE;
      div_cnt    <= '0;
      edge_cnt   <= '0;
      spi_sen_o  <= 1'b1;
      spi_sck_o  <= 1'b0;
      spi_sdat_o <= 1'b0;
      spi_busy_o <= 1'b0;
      spi_done_o <= 1'b0;
    end else begin
      spi_done_o <= 1'b0;
      case (state)
        SPI_IDLE: begin
          div_cnt  <= '0;
          edge_cnt <= '0;
          if (spi_start_i) begin
            tx_sh      <= spi_word_i;
            // msb is on the line before the first rising edge
            spi_sdat_o <= spi_word_i[SPI_FRAME_BITS-1];
            spi_sen_o  <= 1'b0;
            spi_busy_o <= 1'b1;
            state      <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (int'(div_cnt) == SPI_CLK_DIV - 1) begin
            div_cnt   <= '0;
            edge_cnt  <= edge_cnt + 1'b1;
            spi_sck_o <= ~spi_sck_o;
            if (!spi_sck_o) begin
              // rising edge, sample MISO
              rx_sh <= {rx_sh[6:0], spi_sout_i};
            end else if (int'(edge_cnt) == 2 * SPI_FRAME_BITS - 1) begin
              // last falling edge ends the frame
              spi_sen_o <= 1'b1;
              state     <= SPI_DONE;
            end else begin
              // falling edge, next bit out
              tx_sh      <= {tx_sh[SPI_FRAME_BITS-2:0], 1'b0};
              spi_sdat_o <= tx_sh[SPI_FRAME_BITS-2];
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        SPI_DONE: begin
          // one cycle after SEN is back high
          spi_done_o <= 1'b1;
          spi_busy_o <= 1'b0;
          state      <= SPI_IDLE;
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/uart_rx.sv
// UART receiver, 8 data bits, no parity, one stop bit, LSB first
// the line passes two sync flops, so the strobe trails the true
// stop-bit middle by a fixed two cycles
// CLKS_PER_BIT must be at least 4
// a low stop bit drops the byte and raises no error flag

`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = slm_bridge_pkg::DEFAULT_CLKS_PER_BIT
) (
  input  logic                  sys_clk,
  input  logic                  reset_all_cmd_w,
  input  logic                  uart_rx_i,
  output logic                  rx_valid_o,
  output slm_bridge_pkg::byte_t rx_byte_o
);

  import slm_bridge_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t                       state;
  logic [$clog2(CLKS_PER_BIT)-1:0] cnt;
  logic [2:0]                      bit_idx;
  logic                            rx_meta;
  logic                            rx_sync;
  byte_t                           shreg;

  // two-flop sync, idles high
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= uart_rx_i;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state      <= RX_IDLE;
      cnt        <= '0;
      bit_idx    <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          // falling edge marks a possible start bit
          if (!rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // recheck at half a bit to reject glitches
          if (int'(cnt) == CLKS_PER_BIT / 2 - 1) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (int'(cnt) == CLKS_PER_BIT - 1) begin
            cnt <= '0;
            // lsb arrives first, so shift in from the top
            shreg <= {rx_sync, shreg[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (int'(cnt) == CLKS_PER_BIT - 1) begin
            cnt   <= '0;
            state <= RX_IDLE;
            // framing check
            if (rx_sync) begin
              rx_valid_o <= 1'b1;
              rx_byte_o  <= shreg;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/uart_tx.sv
// UART transmitter, 8 data bits, no parity, one stop bit, LSB first
// tx_busy_o rises the cycle after tx_start_i and falls after the stop bit
// a start strobe while busy is ignored
// CLKS_PER_BIT must be at least 4

`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = slm_bridge_pkg::DEFAULT_CLKS_PER_BIT
) (
  input  logic                  sys_clk,
  input  logic                  reset_all_cmd_w,
  input  logic                  tx_start_i,
  input  slm_bridge_pkg::byte_t tx_byte_i,
  output logic                  uart_tx_o,
  output logic                  tx_busy_o
);

  import slm_bridge_pkg::*;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  tx_state_t                       state;
  logic [$clog2(CLKS_PER_BIT)-1:0] cnt;
  logic [2:0]                      bit_idx;
  byte_t                           shreg;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state     <= TX_IDLE;
      cnt       <= '0;
      bit_idx   <= '0;
      uart_tx_o <= 1'b1;
      tx_busy_o <= 1'b0;
    end else begin
      case (state)
        TX_IDLE: begin
          cnt       <= '0;
          uart_tx_o <= 1'b1;
          if (tx_start_i) begin
            shreg     <= tx_byte_i;
            uart_tx_o <= 1'b0;
            tx_busy_o <= 1'b1;
            state     <= TX_START;
          end
        end
        TX_START: begin
          if (int'(cnt) == CLKS_PER_BIT - 1) begin
            cnt       <= '0;
            bit_idx   <= '0;
            uart_tx_o <= shreg[0];
            state     <= TX_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        TX_DATA: begin
          if (int'(cnt) == CLKS_PER_BIT - 1) begin
            cnt <= '0;
            if (bit_idx == 3'd7) begin
              // stop bit
              uart_tx_o <= 1'b1;
              state     <= TX_STOP;
            end else begin
              bit_idx   <= bit_idx + 1'b1;
              shreg     <= {1'b0, shreg[7:1]};
              uart_tx_o <= shreg[1];
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        TX_STOP: begin
          if (int'(cnt) == CLKS_PER_BIT - 1) begin
            cnt       <= '0;
            tx_busy_o <= 1'b0;
            state     <= TX_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: tb/spi_slave_model.sv
// behavioral SLM SPI target, mode 0, MSB first, 16-bit frames
// reply bytes come from a list filled by load_reply, 0 once it is empty
// MISO is 0 during the upper byte of every frame
// frames are recorded at SEN rising and read back with take_frame

`timescale 1ns/1ps
`default_nettype none

module spi_slave_model (
  input  logic spi_sen_i,
  input  logic spi_sck_i,
  input  logic spi_sdat_i,
  output logic spi_sout_o
);

  import slm_bridge_pkg::*;

  byte_t     reply_list [$];
  spi_word_t frame_list [$];
  spi_word_t mosi_sh;
  byte_t     cur_reply;
  int        bit_cnt;
  // guards against X transitions before the DUT leaves reset
  bit        in_frame;

  initial begin
    spi_sout_o = 1'b0;
    bit_cnt    = 0;
    in_frame   = 1'b0;
  end

  task automatic load_reply(input byte_t b);
    reply_list.push_back(b);
  endtask

  function automatic int frame_count();
    return frame_list.size();
  endfunction

  task automatic take_frame(output spi_word_t w);
    w = frame_list.pop_front();
  endtask

  // frame start, next reply byte gets armed
  always @(negedge spi_sen_i) begin
    in_frame = 1'b1;
    bit_cnt  = 0;
    mosi_sh  = '0;
    if (reply_list.size() > 0) begin
      cur_reply = reply_list.pop_front();
    end else begin
      cur_reply = '0;
    end
    spi_sout_o = 1'b0;
  end

  // mosi sampled on rising SCK
  always @(posedge spi_sck_i) begin
    if (in_frame) begin
      mosi_sh = {mosi_sh[SPI_FRAME_BITS-2:0], spi_sdat_i};
      bit_cnt = bit_cnt + 1;
    end
  end

  // next miso bit on falling SCK, bit_cnt is the next index
  always @(negedge spi_sck_i) begin
    if (in_frame && bit_cnt >= 8 && bit_cnt < SPI_FRAME_BITS) begin
      spi_sout_o = cur_reply[SPI_FRAME_BITS-1-bit_cnt];
    end else begin
      spi_sout_o = 1'b0;
    end
  end

  always @(posedge spi_sen_i) begin
    if (in_frame) begin
      in_frame = 1'b0;
      frame_list.push_back(mosi_sh);
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_slm_bridge_top.sv
// directed testbench for the UART to SPI bridge
// UART runs at 16 sys_clk cycles per bit to keep runs short
// behavioral SPI target stands in for the SLM board
// inputs change on the falling clock edge, outputs sampled there too

`timescale 1ns/1ps
`default_nettype none

module tb_slm_bridge_top;

  import slm_bridge_pkg::*;

  localparam int CLKS_PER_BIT = 16;
  // 2 + 2 + 2 * BURST_PAIRS bytes go over the UART
  localparam int BURST_PAIRS = 6;
  localparam int TOTAL_BYTES = 4 + 2 * BURST_PAIRS;
  localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 30 * CLKS_PER_BIT + 2000;
  localparam int FRAME_WAIT = 2 * CLKS_PER_BIT + SPI_FRAME_BITS * 2 * SPI_CLK_DIV + 16;
  localparam int REPLY_WAIT = 30 * CLKS_PER_BIT;

  logic   sys_clk;
  logic   reset_all_cmd_w;
  logic   uart_rx_i;
  logic   spi_sout_i;
  logic   uart_tx_o;
  logic   spi_sen_o;
  logic   spi_sck_o;
  logic   spi_sdat_o;
  logic   slm_reset_n_o;
  int     value_errors = 0;
  int     other_errors = 0;
  int     cycle_cnt = 0;
  integer seed;
  // bytes decoded from uart_tx_o, oldest first
  byte_t  uart_bytes [$];

  slm_bridge_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_slm_bridge_top (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .spi_sout_i      (spi_sout_i),
    .uart_tx_o       (uart_tx_o),
    .spi_sen_o       (spi_sen_o),
    .spi_sck_o       (spi_sck_o),
    .spi_sdat_o      (spi_sdat_o),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  spi_slave_model u_spi_slave_model (
    .spi_sen_i  (spi_sen_o),
    .spi_sck_i  (spi_sck_o),
    .spi_sdat_i (spi_sdat_o),
    .spi_sout_o (spi_sout_i)
  );

  // 40 ns period
  initial sys_clk = 1'b0;
  always #20 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input spi_word_t got, input spi_word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // UART driver and monitor
  //////////////////////////////////////////////////

  // start bit, 8 data bits lsb first, stop bit
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(negedge sys_clk);
      uart_rx_i = frame[i];
      repeat (CLKS_PER_BIT - 1) @(negedge sys_clk);
    end
  endtask

  task automatic capture_uart_byte(output byte_t b);
    int i;
    b = '0;
    while (uart_tx_o !== 1'b0) begin
      @(negedge sys_clk);
    end
    // move to the middle of the start bit
    repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
    if (uart_tx_o !== 1'b0) begin
      other_errors++;
      $display("uart_tx_o start bit did not stay low to its middle");
    end
    for (i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge sys_clk);
      b[i] = uart_tx_o;
    end
    repeat (CLKS_PER_BIT) @(negedge sys_clk);
    if (uart_tx_o !== 1'b1) begin
      other_errors++;
      $display("uart_tx_o stop bit was low, framing error");
    end
  endtask

  initial begin
    byte_t got;
    @(negedge reset_all_cmd_w);
    forever begin
      capture_uart_byte(got);
      uart_bytes.push_back(got);
    end
  end

  // waits for one recorded frame and compares it
  task automatic expect_frame(input spi_word_t exp);
    int        waited;
    spi_word_t got;
    waited = 0;
    while (u_spi_slave_model.frame_count() == 0 && waited < FRAME_WAIT) begin
      @(negedge sys_clk);
      waited++;
    end
    if (u_spi_slave_model.frame_count() == 0) begin
      other_errors++;
      $display("no SPI frame within %0d cycles, expected 0x%h", FRAME_WAIT, exp);
    end else begin
      u_spi_slave_model.take_frame(got);
      check_word("spi frame", got, exp);
    end
  endtask

  task automatic expect_reply(input byte_t exp);
    int    waited;
    byte_t got;
    waited = 0;
    while (uart_bytes.size() == 0 && waited < REPLY_WAIT) begin
      @(negedge sys_clk);
      waited++;
    end
    if (uart_bytes.size() == 0) begin
      other_errors++;
      $display("no UART reply within %0d cycles, expected 0x%h", REPLY_WAIT, exp);
    end else begin
      got = uart_bytes.pop_front();
      check_byte("uart_tx_o byte", got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    int i;
    for (i = 0; i < 4; i++) begin
      @(negedge sys_clk);
      check_bit("uart_tx_o", uart_tx_o, 1'b1);
      check_bit("spi_sen_o", spi_sen_o, 1'b1);
      check_bit("spi_sck_o", spi_sck_o, 1'b0);
      check_bit("slm_reset_n_o", slm_reset_n_o, 1'b0);
    end
    reset_all_cmd_w = 1'b0;
    // low for RESET_HOLD_CYCLES clock edges after release
    for (i = 1; i <= RESET_HOLD_CYCLES + 2; i++) begin
      @(negedge sys_clk);
      check_bit("slm_reset_n_o", slm_reset_n_o, i >= RESET_HOLD_CYCLES);
      check_bit("uart_tx_o", uart_tx_o, 1'b1);
      check_bit("spi_sen_o", spi_sen_o, 1'b1);
      check_bit("spi_sck_o", spi_sck_o, 1'b0);
    end
  endtask

  task automatic test_pairing();
    u_spi_slave_model.load_reply(8'h96);
    send_byte(8'h3a);
    send_byte(8'hc5);
    expect_frame({8'h3a, 8'hc5});
  endtask

  task automatic test_reply_return();
    expect_reply(8'h96);
    if (u_spi_slave_model.frame_count() != 0) begin
      other_errors++;
      $display("more than one SPI frame followed a single byte pair");
    end
  endtask

  task automatic test_odd_byte();
    int i;
    bit sen_fell;
    sen_fell = 1'b0;
    u_spi_slave_model.load_reply(8'h5e);
    send_byte(8'h71);
    for (i = 0; i < 40 * CLKS_PER_BIT; i++) begin
      @(negedge sys_clk);
      if (spi_sen_o !== 1'b1) begin
        sen_fell = 1'b1;
      end
    end
    if (sen_fell || u_spi_slave_model.frame_count() != 0) begin
      other_errors++;
      $display("an SPI frame started after a single unpaired byte");
    end
    // second byte closes the pair with the first
    send_byte(8'h0d);
    expect_frame({8'h71, 8'h0d});
    expect_reply(8'h5e);
  endtask

  task automatic test_burst();
    spi_word_t pairs [BURST_PAIRS];
    byte_t     replies [BURST_PAIRS];
    int        i;
    int        rnd;
    for (i = 0; i < BURST_PAIRS; i++) begin
      rnd        = $random(seed);
      pairs[i]   = rnd[15:0];
      rnd        = $random(seed);
      replies[i] = rnd[7:0];
      u_spi_slave_model.load_reply(replies[i]);
    end
    // no gaps between bytes
    for (i = 0; i < BURST_PAIRS; i++) begin
      send_byte(pairs[i][15:8]);
      send_byte(pairs[i][7:0]);
    end
    for (i = 0; i < BURST_PAIRS; i++) begin
      expect_frame(pairs[i]);
    end
    for (i = 0; i < BURST_PAIRS; i++) begin
      expect_reply(replies[i]);
    end
  endtask

  initial begin
    reset_all_cmd_w = 1'b1;
    uart_rx_i       = 1'b1;
    seed            = 32'hcfc8_6fe1;
    test_reset();
    test_pairing();
    test_reply_return();
    test_odd_byte();
    test_burst();
    if (u_spi_slave_model.frame_count() != 0 || uart_bytes.size() != 0) begin
      other_errors++;
      $display("unexpected SPI frames or UART bytes left at the end");
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
